/* common/t05_pkg.sv */
`default_nettype none

package t05_pkg;

    localparam int CHAR_W = 8;        // character index and left count
    localparam int HEADER_W = 9;      // marker bit + character
    localparam int BYTE_W = 8;
    localparam int BIT_CNT_W = 4;     // field bit counter, counts up to HEADER_W
    localparam int PATH_W = 128;      // 1 = right edge, bit 0 is the deepest edge
    localparam int TRACK_W = 7;
    localparam int NODE_COUNT = 64;
    localparam int NODE_ADDR_W = 6;
    localparam int NODE_W = 13;

    // node word layout
    localparam int LEAF_BIT = 12;
    localparam int LEFT_MSB = 11;
    localparam int LEFT_LSB = 6;
    localparam int RIGHT_MSB = 5;
    localparam int RIGHT_LSB = 0;

    typedef enum logic [2:0] {
        WALK_IDLE,
        WALK_FETCH,
        WALK_CHAR,
        WALK_WAIT_CHAR,
        WALK_BACKTRACK,
        WALK_WAIT_ZERO,
        WALK_DONE
    } walk_state_e;

endpackage

`default_nettype wire

/* common/t05_walk_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface t05_walk_if;
    import t05_pkg::*;

    logic [CHAR_W-1:0] char_index;
    logic char_found;                  // one cycle per leaf
    logic [PATH_W-1:0] curr_path;
    logic [TRACK_W-1:0] track_length;  // current depth
    logic state_3;                     // high once per right edge popped
    logic left;
    logic [CHAR_W-1:0] num_lefts;
    logic write_finish;                // level, cleared by the next char event

    modport walker (
        output char_index, char_found, curr_path, track_length, state_3, left, num_lefts,
        input  write_finish
    );

    modport synth (
        input  char_index, char_found, curr_path, track_length, state_3, left, num_lefts,
        output write_finish
    );

endinterface

`default_nettype wire

/* hdl/t05_htree_walker.sv */
`timescale 1ns/1ps
`default_nettype none

module t05_htree_walker (
    input  logic clk,
    input  logic rst,
    input  logic node_we,
    input  logic [t05_pkg::NODE_ADDR_W-1:0] node_addr,
    input  logic [t05_pkg::NODE_W-1:0] node_data,
    input  logic start,
    t05_walk_if.walker walk,
    output logic walk_done
);
    import t05_pkg::*;

    logic [NODE_W-1:0] node_mem [NODE_COUNT];
    logic [NODE_ADDR_W-1:0] stack_mem [NODE_COUNT];  // ancestor per depth
    walk_state_e state;
    logic [NODE_ADDR_W-1:0] cur;
    logic [PATH_W-1:0] path;
    logic [TRACK_W-1:0] depth;
    logic [TRACK_W-1:0] top;
    logic zero_sent;
    logic [NODE_W-1:0] node_word;
    logic [NODE_W-1:0] parent_word;
    logic is_leaf;
    logic pop_right;
    logic [CHAR_W-1:0] lefts_cnt;

    assign top = depth - TRACK_W'(1);
    assign node_word = node_mem[cur];
    assign parent_word = node_mem[stack_mem[top[NODE_ADDR_W-1:0]]];
    assign is_leaf = node_word[LEAF_BIT];
    assign pop_right = (state == WALK_BACKTRACK) && path[0] && (depth != '0);

    always_ff @(posedge clk) begin
        if (node_we) begin
            node_mem[node_addr] <= node_data;
        end
    end

    // push the parent before stepping into its left child
    always_ff @(posedge clk) begin
        if (state == WALK_FETCH && !is_leaf) begin
            stack_mem[depth[NODE_ADDR_W-1:0]] <= cur;
        end
    end

    // left edges among the valid path bits
    always_comb begin
        lefts_cnt = '0;
        for (int i = 0; i < PATH_W; i++) begin
            if (i < int'(depth) && !path[i]) begin
                lefts_cnt = lefts_cnt + CHAR_W'(1);
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= WALK_IDLE;
            cur <= '0;
            path <= '0;
            depth <= '0;
            zero_sent <= 1'b0;
        end else begin
            case (state)
                WALK_IDLE: begin
                    if (start) begin
                        cur <= '0;  // root lives at address 0
                        path <= '0;
                        depth <= '0;
                        zero_sent <= 1'b0;
                        state <= WALK_FETCH;
                    end
                end
                WALK_FETCH: begin
                    if (is_leaf) begin
                        state <= WALK_CHAR;
                    end else begin
                        path <= {path[PATH_W-2:0], 1'b0};
                        depth <= depth + TRACK_W'(1);
                        cur <= node_word[LEFT_MSB:LEFT_LSB];
                    end
                end
                WALK_CHAR: state <= WALK_WAIT_CHAR;
                WALK_WAIT_CHAR: begin
                    if (walk.write_finish) begin
                        state <= WALK_BACKTRACK;
                    end
                end
                WALK_BACKTRACK: begin
                    if (pop_right) begin
                        path <= path >> 1;  // one zero goes out this cycle
                        depth <= top;
                        zero_sent <= 1'b1;
                    end else if (zero_sent) begin
                        state <= WALK_WAIT_ZERO;
                    end else if (depth == '0) begin
                        state <= WALK_DONE;
                    end else begin
                        // left edge popped silently, take the right branch
                        path[0] <= 1'b1;
                        cur <= parent_word[RIGHT_MSB:RIGHT_LSB];
                        state <= WALK_FETCH;
                    end
                end
                WALK_WAIT_ZERO: begin
                    if (walk.write_finish) begin
                        zero_sent <= 1'b0;
                        state <= WALK_BACKTRACK;
                    end
                end
                WALK_DONE: state <= WALK_IDLE;
                default: state <= WALK_IDLE;
            endcase
        end
    end

    assign walk.char_found = (state == WALK_CHAR);
    assign walk.char_index = node_word[CHAR_W-1:0];
    assign walk.left = (depth != '0) && !path[0];  // reached by a left edge
    assign walk.num_lefts = lefts_cnt;
    assign walk.curr_path = path;
    assign walk.track_length = depth;
    assign walk.state_3 = pop_right;
    assign walk_done = (state == WALK_DONE);

endmodule

`default_nettype wire

/* header_synth/t05_header_synthesis.sv */
`timescale 1ns/1ps
`default_nettype none

module t05_header_synthesis (
    input  logic clk,
    input  logic rst,
    t05_walk_if.synth walk,
    output logic [t05_pkg::HEADER_W-1:0] header,
    output logic enable,
    output logic bit1
);
    import t05_pkg::*;

    logic [BIT_CNT_W-1:0] count;  // bits of the current field already sent
    logic busy;                   // a marker field is loaded or shifting
    logic second;                 // left-count field is the one in flight
    logic zero_run;               // zeros went out in the last cycle
    logic finish;
    logic shift_bit;
    logic field_end;
    logic lefts_due;
    logic zero_req;

    assign shift_bit = busy && (count != BIT_CNT_W'(HEADER_W));
    assign field_end = busy && (count == BIT_CNT_W'(HEADER_W));

    // left leaf with a nonzero count gets a second field
    assign lefts_due = field_end && !second && walk.left && (walk.num_lefts != '0);

    // one zero per right edge popped by the walker
    assign zero_req = walk.state_3 && walk.curr_path[0] && (walk.track_length != '0);

    assign walk.write_finish = finish;

    // header shift register, MSB goes out first
    always_ff @(posedge clk) begin
        if (walk.char_found) begin
            header <= {1'b1, walk.char_index};
        end else if (shift_bit) begin
            header <= {header[HEADER_W-2:0], 1'b0};
        end else if (lefts_due) begin
            header <= {1'b1, walk.num_lefts};
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            count <= '0;
            busy <= 1'b0;
            second <= 1'b0;
            zero_run <= 1'b0;
            finish <= 1'b0;
            enable <= 1'b0;
            bit1 <= 1'b0;
        end else if (walk.char_found) begin
            // header gets loaded this cycle, shifting starts next
            busy <= 1'b1;
            second <= 1'b0;
            count <= '0;
            enable <= 1'b0;
            bit1 <= 1'b0;
            finish <= 1'b0;
        end else if (shift_bit) begin
            enable <= 1'b1;
            bit1 <= header[HEADER_W-1];
            count <= count + BIT_CNT_W'(1);
        end else if (field_end) begin
            enable <= 1'b0;
            bit1 <= 1'b0;
            count <= '0;
            if (lefts_due) begin
                second <= 1'b1;  // idle cycle, then marker + count
            end else begin
                busy <= 1'b0;
                finish <= 1'b1;
            end
        end else if (zero_req) begin
            enable <= 1'b1;
            bit1 <= 1'b0;
            finish <= 1'b0;
            zero_run <= 1'b1;
        end else if (zero_run) begin
            // backtrack run is over
            enable <= 1'b0;
            zero_run <= 1'b0;
            finish <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/t05_bit_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module t05_bit_packer (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  logic bit1,
    input  logic walk_done,
    output logic byte_valid,
    output logic [t05_pkg::BYTE_W-1:0] byte_data,
    output logic done
);
    import t05_pkg::*;

    logic [BYTE_W-1:0] sr;  // pending bits sit in the low end
    logic [2:0] count;
    logic flush;            // padded byte went out

    always_ff @(posedge clk) begin
        if (enable) begin
            sr <= {sr[BYTE_W-2:0], bit1};
        end
        if (enable && count == 3'd7) begin
            byte_data <= {sr[BYTE_W-2:0], bit1};
        end else if (walk_done && count != '0) begin
            byte_data <= sr << (4'd8 - {1'b0, count});  // zero pad the tail
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            count <= '0;
            byte_valid <= 1'b0;
            done <= 1'b0;
            flush <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            done <= flush;
            flush <= 1'b0;
            if (enable) begin
                count <= count + 3'd1;  // wraps after a full byte
                byte_valid <= (count == 3'd7);
            end else if (walk_done) begin
                if (count != '0) begin
                    byte_valid <= 1'b1;
                    flush <= 1'b1;
                    count <= '0;
                end else begin
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/t05_header_top.sv */
`timescale 1ns/1ps
`default_nettype none

module t05_header_top (
    input  logic clk,
    input  logic rst,
    input  logic node_we,
    input  logic [t05_pkg::NODE_ADDR_W-1:0] node_addr,
    input  logic [t05_pkg::NODE_W-1:0] node_data,
    input  logic start,
    output logic byte_valid,
    output logic [t05_pkg::BYTE_W-1:0] byte_data,
    output logic done
);

    logic enable;
    logic bit1;
    logic walk_done;

    t05_walk_if walk ();

    t05_htree_walker u_walker (
        .clk       (clk),
        .rst       (rst),
        .node_we   (node_we),
        .node_addr (node_addr),
        .node_data (node_data),
        .start     (start),
        .walk      (walk.walker),
        .walk_done (walk_done)
    );

    // header kept for probing only
    t05_header_synthesis u_synth (
        .clk    (clk),
        .rst    (rst),
        .walk   (walk.synth),
        .header (),
        .enable (enable),
        .bit1   (bit1)
    );

    t05_bit_packer u_packer (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .bit1       (bit1),
        .walk_done  (walk_done),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .done       (done)
    );

endmodule

`default_nettype wire

/* dv/t05_header_ref.svh */
`ifndef T05_HEADER_REF_SVH
`define T05_HEADER_REF_SVH

// expected header bytes for the tree in nodes, root at address 0
function automatic void t05_expected_bytes(input logic [NODE_W-1:0] nodes [NODE_COUNT],
                                           output logic [7:0] bytes [$]);
    int anc [NODE_COUNT];         // ancestor per depth
    bit went_right [NODE_COUNT];  // edge taken below that ancestor
    bit bits [$];
    int cur;
    int d;
    int lefts;
    bit walking;
    logic [7:0] b;
    cur = 0;
    d = 0;
    walking = 1'b1;
    while (walking) begin
        while (!nodes[cur][LEAF_BIT]) begin
            anc[d] = cur;
            went_right[d] = 1'b0;
            d++;
            cur = int'(nodes[cur][LEFT_MSB:LEFT_LSB]);
        end
        bits.push_back(1'b1);
        for (int i = 7; i >= 0; i--) begin
            bits.push_back(nodes[cur][i]);
        end
        if (d > 0 && !went_right[d-1]) begin
            lefts = 0;
            for (int i = 0; i < d; i++) begin
                if (!went_right[i]) begin
                    lefts++;
                end
            end
            if (lefts != 0) begin
                bits.push_back(1'b1);  // marker, then the count
                for (int i = 7; i >= 0; i--) begin
                    bits.push_back(lefts[i]);
                end
            end
        end
        while (d > 0 && went_right[d-1]) begin
            bits.push_back(1'b0);  // one zero per right edge climbed
            d--;
        end
        if (d == 0) begin
            walking = 1'b0;
        end else begin
            went_right[d-1] = 1'b1;
            cur = int'(nodes[anc[d-1]][RIGHT_MSB:RIGHT_LSB]);
        end
    end
    b = '0;
    for (int i = 0; i < bits.size(); i++) begin
        b = {b[6:0], bits[i]};
        if (i % 8 == 7) begin
            bytes.push_back(b);
            b = '0;
        end
    end
    if (bits.size() % 8 != 0) begin
        bytes.push_back(b << (8 - bits.size() % 8));  // zero pad, MSB first
    end
endfunction

`endif

/* dv/t05_header_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module t05_header_tb;
    import t05_pkg::*;

    `include "t05_header_ref.svh"

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic node_we = 1'b0;
    logic [NODE_ADDR_W-1:0] node_addr = '0;
    logic [NODE_W-1:0] node_data = '0;
    logic start = 1'b0;
    logic byte_valid;
    logic [BYTE_W-1:0] byte_data;
    logic done;

    logic [NODE_W-1:0] tree [NODE_COUNT];
    logic [7:0] exp_q [$];
    logic [7:0] got_q [$];
    integer seed = 32'hbcaf_a686;
    string test_name;
    bit running = 1'b0;
    int finished = 0;    // runs closed by the compare process
    int run_cycles = 0;
    int limit = 0;
    int stray = 0;
    int errors = 0;
    int tests = 0;
    int failed = 0;

    t05_header_top DUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (byte_valid) begin
            if (!running) begin
                $display("byte 0x%02h came out while no run was active", byte_data);
                stray++;
            end
            got_q.push_back(byte_data);
        end
    end

    always @(posedge clk) begin
        int bad;
        if (done && !running) begin
            $display("done pulsed while no run was active");
            stray++;
        end else if (done) begin
            bad = 0;
            if (got_q.size() != exp_q.size()) begin
                $display("ERR %0t byte count: expected %0d, got %0d",
                         $time, exp_q.size(), got_q.size());
                bad++;
            end
            for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
                if (got_q[i] !== exp_q[i]) begin
                    $display("ERR %0t byte_data[%0d]: expected 0x%02h, got 0x%02h",
                             $time, i, exp_q[i], got_q[i]);
                    bad++;
                end
            end
            $display("test %-12s %0d bytes, %s", test_name, got_q.size(),
                     (bad == 0) ? "ok" : "failed");
            errors += bad;
            tests++;
            if (bad != 0) begin
                failed++;
            end
            finished <= finished + 1;
        end
    end

    // watchdog with a per-run limit
    always @(posedge clk) begin
        if (running) begin
            run_cycles <= run_cycles + 1;
        end else begin
            run_cycles <= 0;
        end
        if (running && run_cycles > limit) begin
            $display("timeout: %s did not reach done within %0d cycles", test_name, limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [NODE_W-1:0] leaf_word(input logic [7:0] ch);
        return {1'b1, 4'b0, ch};
    endfunction

    function automatic logic [NODE_W-1:0] inner_word(input int l, input int r);
        return {1'b0, 6'(l), 6'(r)};
    endfunction

    function automatic void clear_tree();
        for (int a = 0; a < NODE_COUNT; a++) begin
            tree[a] = '0;
        end
    endfunction

    // split a random leaf until the leaf count is reached
    function automatic void build_random_tree();
        int leaves [$];
        int n;
        int pick;
        int next;
        n = 1 + int'($unsigned($random(seed)) % 32);
        clear_tree();
        tree[0] = leaf_word(8'($random(seed)));
        leaves.push_back(0);
        next = 1;
        while (leaves.size() < n) begin
            pick = int'($unsigned($random(seed)) % leaves.size());
            tree[leaves[pick]] = inner_word(next, next + 1);
            tree[next] = leaf_word(8'($random(seed)));
            tree[next + 1] = leaf_word(8'($random(seed)));
            leaves[pick] = next;
            leaves.push_back(next + 1);
            next += 2;
        end
    endfunction

    task automatic run_tree(input string name);
        int seen;
        t05_expected_bytes(tree, exp_q);
        limit = 40 * 8 * exp_q.size() + 200;
        test_name = name;
        for (int a = 0; a < NODE_COUNT; a++) begin
            @(posedge clk);
            node_we <= 1'b1;
            node_addr <= NODE_ADDR_W'(a);
            node_data <= tree[a];
        end
        @(posedge clk);
        node_we <= 1'b0;
        got_q.delete();
        seen = finished;
        @(posedge clk);
        start <= 1'b1;
        running <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait (finished != seen);
        running <= 1'b0;
        repeat (16) @(posedge clk);  // idle gap where a late done or byte would show up
    endtask

    initial begin
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        clear_tree();
        tree[0] = leaf_word(8'ha5);
        run_tree("single_leaf");
        clear_tree();
        tree[0] = inner_word(1, 2);
        tree[1] = leaf_word(8'h41);
        tree[2] = inner_word(3, 4);
        tree[3] = leaf_word(8'h42);
        tree[4] = leaf_word(8'h43);
        run_tree("three_leaf");
        clear_tree();
        for (int i = 0; i < 8; i++) begin
            tree[i] = inner_word((i == 7) ? 8 : i + 1, 9 + i);  // left spine
            tree[9 + i] = leaf_word(8'(8'h60 + i));
        end
        tree[8] = leaf_word(8'h5f);
        run_tree("left_chain");
        for (int t = 0; t < 10; t++) begin
            build_random_tree();
            run_tree($sformatf("random_%0d", t));
        end
        // restart with a freshly loaded right spine
        clear_tree();
        for (int i = 0; i < 4; i++) begin
            tree[i] = inner_word(5 + i, (i == 3) ? 4 : i + 1);
            tree[5 + i] = leaf_word(8'(8'h30 + i));
        end
        tree[4] = leaf_word(8'h7e);
        run_tree("restart");
        $display("%0d tests, %0d failed, %0d errors, %0d stray events",
                 tests, failed, errors, stray);
        if (errors == 0 && failed == 0 && stray == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+dv
common/t05_pkg.sv
common/t05_walk_if.sv
hdl/t05_htree_walker.sv
header_synth/t05_header_synthesis.sv
hdl/t05_bit_packer.sv
hdl/t05_header_top.sv
dv/t05_header_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= t05_header_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(BUILD_DIR)
